//--- hdl/sort_key_pkg.sv
package sort_key_pkg;

   localparam int KEY_W = 32;

   // Keys in one merged output block.
   localparam int QUAD_LANES = 4;

   typedef logic [KEY_W-1:0] key_t;

   // Two keys, lo not greater than hi once sorted.
   typedef struct packed {
      key_t hi;
      key_t lo;
   } pair_t;

   // Four keys, ascending from k0.
   typedef struct packed {
      key_t k3;
      key_t k2;
      key_t k1;
      key_t k0;
   } quad_t;

   // Basic compare-swap element of every network stage.
   function automatic pair_t sort2(input key_t a, input key_t b);
      pair_t p;
      if (b >= a) begin
         p.lo = a;
         p.hi = b;
      end else begin
         p.lo = b;
         p.hi = a;
      end
      return p;
   endfunction

endpackage

//--- hdl/sort_buf_pkg.sv
package sort_buf_pkg;

   // Pair entries in the FIFO.
   localparam int FIFO_DEPTH = 8;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // Occupancy runs from 0 to FIFO_DEPTH inclusive.
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

   // One slot stays free for the pair still inside the pair sorter.
   localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(FIFO_DEPTH - 1);

endpackage

//--- hdl/pair_if.sv
// Write side, pair sorter into FIFO.
interface pair_wr_if;

   logic                wr_en;
   sort_key_pkg::pair_t wr_pair;
   logic                wr_last;
   logic                full;

   modport src (
      output wr_en,
      output wr_pair,
      output wr_last,
      input  full
   );

   modport dst (
      input  wr_en,
      input  wr_pair,
      input  wr_last,
      output full
   );

endinterface

// Read side, FIFO into merge network.
interface pair_rd_if;

   logic [sort_buf_pkg::CNT_W-1:0] count;
   sort_key_pkg::pair_t            rd_pair;
   logic                           rd_last;
   logic                           rd_en;

   modport src (
      output count,
      output rd_pair,
      output rd_last,
      input  rd_en
   );

   modport dst (
      input  count,
      input  rd_pair,
      input  rd_last,
      output rd_en
   );

endinterface

//--- hdl/pair_sorter.sv
module pair_sorter (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_valid,
   input  sort_key_pkg::key_t  i_key_a,
   input  sort_key_pkg::key_t  i_key_b,
   input  logic                i_last,
   pair_wr_if.src              wr
);

   sort_key_pkg::pair_t sorted;

   // Smaller key goes to lo.
   assign sorted = sort_key_pkg::sort2(i_key_a, i_key_b);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr.wr_en <= 1'b0;
      end else begin
         wr.wr_en <= i_valid;
      end
   end

   // Payload only moves on a valid strobe.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         wr.wr_pair <= sorted;
         wr.wr_last <= i_last;
      end
   end

endmodule

//--- hdl/pair_fifo.sv
module pair_fifo (
   input  logic    i_clk,
   input  logic    i_rst_n,
   pair_wr_if.dst  wr,
   pair_rd_if.src  rd
);

   sort_key_pkg::pair_t mem_pair [sort_buf_pkg::FIFO_DEPTH];
   logic                mem_last [sort_buf_pkg::FIFO_DEPTH];

   logic [sort_buf_pkg::PTR_W-1:0] wr_ptr;
   logic [sort_buf_pkg::PTR_W-1:0] rd_ptr;
   logic [sort_buf_pkg::CNT_W-1:0] count;

   // Storage.
   always_ff @(posedge i_clk) begin
      if (wr.wr_en) begin
         mem_pair[wr_ptr] <= wr.wr_pair;
         mem_last[wr_ptr] <= wr.wr_last;
      end
   end

   // Pointers wrap at the last slot so any depth works.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr.wr_en) begin
            wr_ptr <= (wr_ptr == sort_buf_pkg::LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (rd.rd_en) begin
            rd_ptr <= (rd_ptr == sort_buf_pkg::LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         count <= '0;
      end else begin
         case ({wr.wr_en, rd.rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head of the queue is shown straight from storage.
   assign rd.rd_pair = mem_pair[rd_ptr];
   assign rd.rd_last = mem_last[rd_ptr];
   assign rd.count   = count;

   assign wr.full = (count >= sort_buf_pkg::FULL_LEVEL);

   // The source has to respect full, so a write never lands on a full buffer.
   a_no_overflow: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      wr.wr_en |-> (count != sort_buf_pkg::FIFO_DEPTH)
   ) else $error("pair_fifo: write at full depth");

   a_no_underflow: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      rd.rd_en |-> (count != '0)
   ) else $error("pair_fifo: read from empty buffer");

endmodule

//--- hdl/bitonic_merge_4.sv
module bitonic_merge_4 (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_stall,
   pair_rd_if.dst              rd,
   output logic                o_valid,
   output sort_key_pkg::quad_t o_quad,
   output logic                o_last
);

   // Lanes 0 to 3 hold min lo, max lo, min hi, max hi after stage 1.
   typedef sort_key_pkg::key_t [sort_key_pkg::QUAD_LANES-1:0] lanes_t;

   logic                pop;
   logic                pop_second;
   logic                hold_vld;
   sort_key_pkg::pair_t hold_pair;
   sort_key_pkg::pair_t lo_cs;
   sort_key_pkg::pair_t hi_cs;
   sort_key_pkg::pair_t mid_cs;
   logic                s1_vld;
   lanes_t              s1_key;
   logic                s1_last;
   logic                s2_vld;
   lanes_t              s2_key;
   logic                s2_last;

   // No pops while stalled.
   assign pop        = !i_stall && (rd.count != '0);
   assign pop_second = pop && hold_vld;
   assign rd.rd_en   = pop;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         hold_vld <= 1'b0;
      end else if (pop) begin
         hold_vld <= !hold_vld;
      end
   end

   // First pair of a block waits here for its partner.
   always_ff @(posedge i_clk) begin
      if (pop && !hold_vld) begin
         hold_pair <= rd.rd_pair;
      end
   end

   assign lo_cs  = sort_key_pkg::sort2(hold_pair.lo, rd.rd_pair.lo);
   assign hi_cs  = sort_key_pkg::sort2(hold_pair.hi, rd.rd_pair.hi);
   assign mid_cs = sort_key_pkg::sort2(s1_key[1], s1_key[2]);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         s1_vld <= 1'b0;
         s2_vld <= 1'b0;
      end else if (!i_stall) begin
         s1_vld <= pop_second;
         s2_vld <= s1_vld;
      end
   end

   // Stage 1, lo against lo and hi against hi.
   always_ff @(posedge i_clk) begin
      if (pop_second) begin
         s1_key  <= {hi_cs.hi, hi_cs.lo, lo_cs.hi, lo_cs.lo};
         s1_last <= rd.rd_last;
      end
   end

   // Stage 2, outer keys are final, the middle two get swapped.
   always_ff @(posedge i_clk) begin
      if (!i_stall && s1_vld) begin
         s2_key  <= {s1_key[3], mid_cs.hi, mid_cs.lo, s1_key[0]};
         s2_last <= s1_last;
      end
   end

   assign o_valid   = s2_vld && !i_stall;
   assign o_quad.k0 = s2_key[0];
   assign o_quad.k1 = s2_key[1];
   assign o_quad.k2 = s2_key[2];
   assign o_quad.k3 = s2_key[3];
   assign o_last    = s2_last;

   // Two sorted pairs must always come out as one ascending block.
   a_quad_ascending: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      s2_vld |-> ((s2_key[0] <= s2_key[1]) && (s2_key[1] <= s2_key[2]) &&
                  (s2_key[2] <= s2_key[3]))
   ) else $error("bitonic_merge_4: block not ascending");

endmodule

//--- hdl/quad_sorter.sv
module quad_sorter (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_valid,
   input  sort_key_pkg::key_t  i_key_a,
   input  sort_key_pkg::key_t  i_key_b,
   input  logic                i_last,
   input  logic                i_stall,
   output logic                o_full,
   output logic                o_valid,
   output sort_key_pkg::quad_t o_quad,
   output logic                o_last
);

   pair_wr_if wr_bus ();
   pair_rd_if rd_bus ();

   // Producer, orders each raw pair.
   pair_sorter i_pair_sorter (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_valid (i_valid),
      .i_key_a (i_key_a),
      .i_key_b (i_key_b),
      .i_last  (i_last),
      .wr      (wr_bus)
   );

   // Buffer, absorbs downstream stalls.
   pair_fifo i_pair_fifo (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .wr      (wr_bus),
      .rd      (rd_bus)
   );

   // Consumer, merges two pairs into one block of four.
   bitonic_merge_4 i_merge (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_stall (i_stall),
      .rd      (rd_bus),
      .o_valid (o_valid),
      .o_quad  (o_quad),
      .o_last  (o_last)
   );

   // Source holds off while this is high.
   assign o_full = wr_bus.full;

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 3
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

   // Reset is released on a falling edge, away from the sampling edge.
   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

//--- tb/tb_quad_sorter.sv
module tb_quad_sorter;

   localparam int MAX_QUADS   = 256;
   localparam int WAIT_CYCLES = 400;
   localparam int EDGE_PAIRS  = 14;

   logic                clk;
   logic                rst_n;
   logic                valid;
   sort_key_pkg::key_t  key_a;
   sort_key_pkg::key_t  key_b;
   logic                last;
   logic                stall;
   logic                full;
   logic                out_valid;
   sort_key_pkg::quad_t out_quad;
   logic                out_last;

   // Expected blocks, written by the stimulus and consumed on each o_valid.
   sort_key_pkg::quad_t exp_quad [MAX_QUADS];
   logic                exp_last [MAX_QUADS];
   int                  exp_wr = 0;
   int                  exp_rd = 0;

   // First pair of a block, waiting for its partner.
   sort_key_pkg::key_t  held_a;
   sort_key_pkg::key_t  held_b;
   logic                held_vld = 1'b0;

   logic idle_phase = 1'b0;
   logic bp_phase   = 1'b0;
   logic wr_seen    = 1'b0;
   int   bp_count   = 0;
   logic feed_done  = 1'b0;

   int err_cnt   = 0;
   int err_base  = 0;
   int tests_run = 0;

   sort_key_pkg::key_t edge_a [EDGE_PAIRS] = '{
      32'h0, 32'h0, 32'hFFFF_FFFF, 32'h0, 32'h5, 32'h5, 32'h1,
      32'h3, 32'h4, 32'h2, 32'hFFFF_FFFF, 32'h0, 32'h7, 32'h7
   };
   sort_key_pkg::key_t edge_b [EDGE_PAIRS] = '{
      32'h0, 32'h0, 32'h0, 32'hFFFF_FFFF, 32'h5, 32'h5, 32'h2,
      32'h4, 32'h3, 32'h1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h7, 32'h3
   };

   tb_clock_gen #(
      .PERIOD     (20),
      .RST_CYCLES (3)
   ) i_clock_gen (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   quad_sorter i_dut (
      .i_clk   (clk),
      .i_rst_n (rst_n),
      .i_valid (valid),
      .i_key_a (key_a),
      .i_key_b (key_b),
      .i_last  (last),
      .i_stall (stall),
      .o_full  (full),
      .o_valid (out_valid),
      .o_quad  (out_quad),
      .o_last  (out_last)
   );

   // Write strobe one edge after i_valid, counted one edge later.
   always @(posedge clk) begin
      if (out_valid) begin
         exp_rd <= exp_rd + 1;
      end
      wr_seen <= valid;
      if (!bp_phase) begin
         bp_count <= 0;
      end else if (wr_seen) begin
         bp_count <= bp_count + 1;
      end
   end

   task automatic report_mismatch(input string msg);
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   a_idle_quiet: assert property (
      @(posedge clk) disable iff (!rst_n)
      idle_phase |-> (!out_valid && !full)
   ) else report_mismatch("output active before any input");

   a_block_expected: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> (exp_rd < exp_wr)
   ) else report_mismatch("o_valid with no block expected");

   a_quad_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> (out_quad == exp_quad[exp_rd])
   ) else report_mismatch($sformatf("o_quad %h, expected %h", $sampled(out_quad),
                                    exp_quad[$sampled(exp_rd)]));

   a_last_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> (out_last == exp_last[exp_rd])
   ) else report_mismatch($sformatf("o_last %b, expected %b", $sampled(out_last),
                                    exp_last[$sampled(exp_rd)]));

   a_ascending: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> ((out_quad.k0 <= out_quad.k1) && (out_quad.k1 <= out_quad.k2) &&
                     (out_quad.k2 <= out_quad.k3))
   ) else report_mismatch($sformatf("o_quad %h not ascending", $sampled(out_quad)));

   a_stall_quiet: assert property (
      @(posedge clk) disable iff (!rst_n)
      stall |-> !out_valid
   ) else report_mismatch("o_valid high during stall");

   a_full_level: assert property (
      @(posedge clk) disable iff (!rst_n)
      bp_phase |-> (full == (bp_count >= sort_buf_pkg::FULL_LEVEL))
   ) else report_mismatch($sformatf("o_full %b with %0d pairs written",
                                    $sampled(full), $sampled(bp_count)));

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $finish;
   endtask

   // Plain insertion sort of the four keys of one block.
   function automatic sort_key_pkg::quad_t sorted_quad(input sort_key_pkg::key_t a0,
                                                        input sort_key_pkg::key_t a1,
                                                        input sort_key_pkg::key_t b0,
                                                        input sort_key_pkg::key_t b1);
      sort_key_pkg::key_t  v [4];
      sort_key_pkg::key_t  t;
      sort_key_pkg::quad_t q;
      int                  j;
      v[0] = a0;
      v[1] = a1;
      v[2] = b0;
      v[3] = b1;
      for (int i = 1; i < 4; i++) begin
         t = v[i];
         j = i - 1;
         while (j >= 0 && v[j] > t) begin
            v[j+1] = v[j];
            j = j - 1;
         end
         v[j+1] = t;
      end
      q.k0 = v[0];
      q.k1 = v[1];
      q.k2 = v[2];
      q.k3 = v[3];
      return q;
   endfunction

   task automatic add_to_model(input sort_key_pkg::key_t a, input sort_key_pkg::key_t b,
                               input logic l);
      if (!held_vld) begin
         held_a   = a;
         held_b   = b;
         held_vld = 1'b1;
      end else begin
         exp_quad[exp_wr] = sorted_quad(held_a, held_b, a, b);
         exp_last[exp_wr] = l;
         exp_wr   = exp_wr + 1;
         held_vld = 1'b0;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_while_full();
      int n;
      n = 0;
      while (full && n < WAIT_CYCLES) begin
         @(negedge clk);
         n = n + 1;
      end
      if (full) begin
         abort_run("timeout: o_full stayed high");
      end
   endtask

   // Called on a falling edge; holds i_valid for one cycle.
   task automatic send_pair(input sort_key_pkg::key_t a, input sort_key_pkg::key_t b,
                            input logic l);
      wait_while_full();
      valid = 1'b1;
      key_a = a;
      key_b = b;
      last  = l;
      add_to_model(a, b, l);
      @(negedge clk);
      valid = 1'b0;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_rd != exp_wr && n < WAIT_CYCLES) begin
         @(negedge clk);
         n = n + 1;
      end
      if (exp_rd != exp_wr) begin
         abort_run("timeout: expected blocks did not all come out");
      end
      // Extra cycles catch any repeated block.
      idle_cycles(6);
   endtask

   task automatic finish_test(input string name);
      tests_run = tests_run + 1;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
      err_base = err_cnt;
   endtask

   task automatic run_reset_test();
      int n;
      n = 0;
      while (!rst_n && n < 20) begin
         @(negedge clk);
         n = n + 1;
      end
      if (!rst_n) begin
         abort_run("timeout: reset never released");
      end
      idle_phase = 1'b1;
      idle_cycles(10);
      idle_phase = 1'b0;
      finish_test("after reset");
   endtask

   task automatic run_random_test();
      for (int i = 0; i < 30; i++) begin
         send_pair($urandom, $urandom, 1'($urandom_range(0, 1)));
         idle_cycles($urandom_range(1, 4));
      end
      wait_drained();
      finish_test("random keys low rate");
   endtask

   task automatic run_edge_test();
      for (int i = 0; i < EDGE_PAIRS; i++) begin
         send_pair(edge_a[i], edge_b[i], (i == EDGE_PAIRS - 1));
      end
      wait_drained();
      finish_test("equal and edge keys");
   endtask

   task automatic run_stall_test();
      int n;
      n = 0;
      feed_done = 1'b0;
      fork
         begin
            for (int i = 0; i < 40; i++) begin
               send_pair($urandom, $urandom, 1'($urandom_range(0, 1)));
               idle_cycles($urandom_range(0, 2));
            end
            feed_done = 1'b1;
         end
         begin
            while (!feed_done && n < WAIT_CYCLES) begin
               stall = $urandom_range(0, 1);
               idle_cycles($urandom_range(1, 6));
               n = n + 1;
            end
            stall = 1'b0;
         end
      join
      wait_drained();
      finish_test("random stall");
   endtask

   task automatic run_backpressure_test();
      int n;
      n = 0;
      stall    = 1'b1;
      bp_phase = 1'b1;
      while (!full && n < WAIT_CYCLES) begin
         send_pair($urandom, $urandom, 1'($urandom_range(0, 1)));
         n = n + 1;
      end
      if (!full) begin
         abort_run("timeout: o_full never rose under stall");
      end
      idle_cycles(5);
      stall    = 1'b0;
      bp_phase = 1'b0;
      if (held_vld) begin
         send_pair($urandom, $urandom, 1'b1);
      end
      for (int i = 0; i < 4; i++) begin
         send_pair($urandom, $urandom, (i == 3));
      end
      wait_drained();
      finish_test("back-pressure");
   endtask

   initial begin
      valid = 1'b0;
      key_a = '0;
      key_b = '0;
      last  = 1'b0;
      stall = 1'b0;
      void'($urandom(71));

      run_reset_test();
      run_random_test();
      run_edge_test();
      run_stall_test();
      run_backpressure_test();

      $display("summary: %0d tests, %0d blocks checked, %0d errors",
               tests_run, exp_rd, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- quad_sorter.f
hdl/sort_key_pkg.sv
hdl/sort_buf_pkg.sv
hdl/pair_if.sv
hdl/pair_sorter.sv
hdl/pair_fifo.sv
hdl/bitonic_merge_4.sv
hdl/quad_sorter.sv
tb/tb_clock_gen.sv
tb/tb_quad_sorter.sv
